// File: cache_bus_if.sv
`timescale 1ns/1ps

// Native request/response bus between cache levels
interface cache_bus_if import cache_pkg::*; ();

   logic        valid;   // Request pending, held until ready
   cache_addr_t addr;
   cache_word_t wdata;
   cache_strb_t wstrb;   // Any bit set makes it a write
   cache_word_t rdata;   // Valid only with ready
   logic        ready;   // Single-cycle completion pulse

   // Requester side
   modport master (output valid, addr, wdata, wstrb,
                   input  rdata, ready);

   // Responder side
   modport slave  (input  valid, addr, wdata, wstrb,
                   output rdata, ready);

endinterface

// File: cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////////////////////////
// Word geometry
//////////////////////////////////////////////////
`define CACHE_ADDR_W 12                     // Word address, 4K words
`define CACHE_DATA_W 32                     // One word per line
`define CACHE_STRB_W (`CACHE_DATA_W / 8)    // One strobe per byte lane

//////////////////////////////////////////////////
// Cache sizes
//////////////////////////////////////////////////
`define L1_IDX_W 4                          // 16 lines in each L1
`define L2_IDX_W 7                          // 128 lines in the shared L2

`endif

// File: cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

   typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;   // Word address
   typedef logic [`CACHE_DATA_W-1:0] cache_word_t;   // Data word
   typedef logic [`CACHE_STRB_W-1:0] cache_strb_t;   // Byte write strobes

   // Controller states shared by L1 and L2
   typedef enum logic [2:0] {
      IDLE,        // Waiting for a request
      LOOKUP,      // Registered decode of miss or write
      MEM_READ,    // Line fetch from the next level
      MEM_WRITE,   // Write-through to the next level
      RESPOND      // One-cycle ready pulse
   } cache_state_t;

   // Strobed bytes of new_w replace the matching bytes of old_w
   function automatic cache_word_t merge_bytes(cache_word_t old_w, cache_word_t new_w,
                                               cache_strb_t strb);
      cache_word_t res;
      res = old_w;
      for (int b = 0; b < `CACHE_STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

// File: l1_cache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module l1_cache import cache_pkg::*; #(
   parameter int IDX_W = `L1_IDX_W          // 2**IDX_W direct-mapped lines
) (
   input  logic        clk,
   input  logic        i_rst,
   input  logic        i_valid,
   input  cache_addr_t i_addr,
   input  cache_word_t i_wdata,
   input  cache_strb_t i_wstrb,
   output cache_word_t o_rdata,
   output logic        o_ready,
   cache_bus_if.master mem                  // Toward the arbiter
);

   localparam int TAG_W = `CACHE_ADDR_W - IDX_W;
   localparam int LINES = 1 << IDX_W;

   cache_state_t     state;

   // Request latched on acceptance
   cache_addr_t      req_addr;
   cache_word_t      req_wdata;
   cache_strb_t      req_wstrb;

   // Line storage
   logic [TAG_W-1:0] tag_mem  [LINES];
   cache_word_t      data_mem [LINES];
   logic [LINES-1:0] line_vld;              // One valid bit per line

   logic [IDX_W-1:0] in_idx, req_idx;
   logic [TAG_W-1:0] in_tag, req_tag;
   logic             in_hit, req_hit;

   //////////////////////////////////////////////////
   // Tag compare
   //////////////////////////////////////////////////
   assign in_idx  = i_addr[IDX_W-1:0];
   assign in_tag  = i_addr[`CACHE_ADDR_W-1:IDX_W];
   assign req_idx = req_addr[IDX_W-1:0];
   assign req_tag = req_addr[`CACHE_ADDR_W-1:IDX_W];

   // Incoming address drives the one-cycle read hit
   assign in_hit  = line_vld[in_idx] && (tag_mem[in_idx] == in_tag);
   // Latched address drives the write-hit merge
   assign req_hit = line_vld[req_idx] && (tag_mem[req_idx] == req_tag);

   //////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= IDLE;
         line_vld <= '0;                    // Cache comes up empty
      end else begin
         case (state)
            IDLE: begin
               if (i_valid) begin
                  if (in_hit && !(|i_wstrb))
                     state <= RESPOND;      // Read hit answers next cycle
                  else
                     state <= LOOKUP;
               end
            end
            LOOKUP: state <= (|req_wstrb) ? MEM_WRITE : MEM_READ;
            MEM_READ: begin
               if (mem.ready) begin
                  line_vld[req_idx] <= 1'b1;   // Fill on read miss
                  state             <= RESPOND;
               end
            end
            MEM_WRITE: begin
               if (mem.ready)
                  state <= RESPOND;         // No allocate on write miss
            end
            RESPOND: state <= IDLE;         // Master may drop valid in this cycle
            default: state <= IDLE;
         endcase
      end
   end

   // Payload and arrays
   always_ff @(posedge clk) begin
      if (state == IDLE && i_valid) begin
         req_addr  <= i_addr;
         req_wdata <= i_wdata;
         req_wstrb <= i_wstrb;
         o_rdata   <= data_mem[in_idx];     // Read-hit data
      end
      if (state == LOOKUP && (|req_wstrb) && req_hit)
         data_mem[req_idx] <= merge_bytes(data_mem[req_idx], req_wdata, req_wstrb);
      if (state == MEM_READ && mem.ready) begin
         data_mem[req_idx] <= mem.rdata;
         tag_mem[req_idx]  <= req_tag;
         o_rdata           <= mem.rdata;    // Forward fetched word
      end
   end

   assign o_ready   = (state == RESPOND);
   assign mem.valid = (state == MEM_READ) || (state == MEM_WRITE);
   assign mem.addr  = req_addr;
   assign mem.wdata = req_wdata;
   assign mem.wstrb = req_wstrb;            // Zero for reads

   // Front end keeps the request still until it gets ready
   a_req_stable: assert property (@(posedge clk) disable iff (i_rst)
      (i_valid && !o_ready) |=> (o_ready ||
         (i_valid && $stable(i_addr) && $stable(i_wdata) && $stable(i_wstrb))));

   // Each ready answers a request seen in the previous cycle
   a_ready_pending: assert property (@(posedge clk) disable iff (i_rst)
      o_ready |-> $past(i_valid));

endmodule

// File: l2_arbiter.sv
`timescale 1ns/1ps

module l2_arbiter (
   input  logic        clk,
   input  logic        i_rst,
   cache_bus_if.slave  l1i,                 // Instruction cache misses
   cache_bus_if.slave  l1d,                 // Data cache misses and writes
   cache_bus_if.master l2                   // Shared L2 front end
);

   logic busy;                              // Transfer in flight at L2
   logic owner_d;                           // Data side holds the grant
   logic sel_d;                             // Current data-side select

   //////////////////////////////////////////////////
   // Grant
   //////////////////////////////////////////////////
   // Fresh grant when free, instruction side wins ties
   assign sel_d = busy ? owner_d : !l1i.valid;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy    <= 1'b0;
         owner_d <= 1'b0;
      end else if (l2.ready) begin
         busy <= 1'b0;                      // Released on the ready pulse
      end else if (!busy && l2.valid) begin
         busy    <= 1'b1;
         owner_d <= sel_d;                  // Lock the winner
      end
   end

   //////////////////////////////////////////////////
   // Request mux and response steer
   //////////////////////////////////////////////////
   assign l2.valid  = sel_d ? l1d.valid : l1i.valid;
   assign l2.addr   = sel_d ? l1d.addr  : l1i.addr;
   assign l2.wdata  = sel_d ? l1d.wdata : l1i.wdata;
   assign l2.wstrb  = sel_d ? l1d.wstrb : l1i.wstrb;

   assign l1i.rdata = l2.rdata;             // Shared read data
   assign l1d.rdata = l2.rdata;
   assign l1i.ready = l2.ready && !sel_d;   // Only the owner sees ready
   assign l1d.ready = l2.ready && sel_d;

   // Grant stays put from acceptance until L2 completes
   a_grant_hold: assert property (@(posedge clk) disable iff (i_rst)
      (l2.valid && !l2.ready) |=> (sel_d == $past(sel_d)));

endmodule

// File: l2_cache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module l2_cache import cache_pkg::*; #(
   parameter int IDX_W = `L2_IDX_W          // 2**IDX_W direct-mapped lines
) (
   input  logic        clk,
   input  logic        i_rst,
   cache_bus_if.slave  front,               // From the arbiter
   output logic        o_mem_valid,
   output cache_addr_t o_mem_addr,
   output cache_word_t o_mem_wdata,
   output cache_strb_t o_mem_wstrb,
   input  logic        i_mem_ready,
   input  cache_word_t i_mem_rdata
);

   localparam int TAG_W = `CACHE_ADDR_W - IDX_W;
   localparam int LINES = 1 << IDX_W;

   cache_state_t     state;

   cache_addr_t      req_addr;              // Latched front request
   cache_word_t      req_wdata;
   cache_strb_t      req_wstrb;
   cache_word_t      rdata_q;

   logic [TAG_W-1:0] tag_mem  [LINES];
   cache_word_t      data_mem [LINES];
   logic [LINES-1:0] line_vld;

   logic [IDX_W-1:0] in_idx, req_idx;
   logic [TAG_W-1:0] in_tag, req_tag;
   logic             in_hit, req_hit;

   assign in_idx  = front.addr[IDX_W-1:0];
   assign in_tag  = front.addr[`CACHE_ADDR_W-1:IDX_W];
   assign req_idx = req_addr[IDX_W-1:0];
   assign req_tag = req_addr[`CACHE_ADDR_W-1:IDX_W];
   assign in_hit  = line_vld[in_idx] && (tag_mem[in_idx] == in_tag);
   assign req_hit = line_vld[req_idx] && (tag_mem[req_idx] == req_tag);

   //////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= IDLE;
         line_vld <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (front.valid) begin
                  // Read hit is the only one-cycle path
                  state <= (in_hit && !(|front.wstrb)) ? RESPOND : LOOKUP;
               end
            end
            LOOKUP: state <= (|req_wstrb) ? MEM_WRITE : MEM_READ;
            MEM_READ: begin
               if (i_mem_ready) begin
                  line_vld[req_idx] <= 1'b1;
                  state             <= RESPOND;
               end
            end
            MEM_WRITE: begin
               if (i_mem_ready)
                  state <= RESPOND;         // Write acked once memory takes it
            end
            RESPOND: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && front.valid) begin
         req_addr  <= front.addr;
         req_wdata <= front.wdata;
         req_wstrb <= front.wstrb;
         rdata_q   <= data_mem[in_idx];
      end
      // Write hit updates the line, a write miss leaves it alone
      if (state == LOOKUP && (|req_wstrb) && req_hit)
         data_mem[req_idx] <= merge_bytes(data_mem[req_idx], req_wdata, req_wstrb);
      if (state == MEM_READ && i_mem_ready) begin
         data_mem[req_idx] <= i_mem_rdata;
         tag_mem[req_idx]  <= req_tag;
         rdata_q           <= i_mem_rdata;
      end
   end

   assign front.ready = (state == RESPOND);
   assign front.rdata = rdata_q;

   //////////////////////////////////////////////////
   // Memory port
   //////////////////////////////////////////////////
   assign o_mem_valid = (state == MEM_READ) || (state == MEM_WRITE);
   assign o_mem_addr  = req_addr;           // Held by the latch until ready
   assign o_mem_wdata = req_wdata;
   assign o_mem_wstrb = req_wstrb;

   // Memory request held steady under back-pressure
   a_mem_hold: assert property (@(posedge clk) disable iff (i_rst)
      (o_mem_valid && !i_mem_ready) |=> (o_mem_valid && $stable(o_mem_addr) &&
         $stable(o_mem_wdata) && $stable(o_mem_wstrb)));

endmodule

// File: l2_id_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module l2_id_tb import cache_pkg::*; ();

   localparam int MEM_WORDS  = 1 << `CACHE_ADDR_W;
   localparam int NUM_OPS    = 600;
   localparam int MAX_CYCLES = NUM_OPS * 24 + 5600;   // Worst case per op plus margin

   logic        clk, i_rst;
   logic        i_valid, i_instr;
   cache_addr_t i_addr;
   cache_word_t i_wdata, o_rdata;
   cache_strb_t i_wstrb;
   logic        o_ready;
   logic        o_mem_valid, i_mem_ready;
   cache_addr_t o_mem_addr;
   cache_word_t o_mem_wdata;
   cache_strb_t o_mem_wstrb;
   cache_word_t i_mem_rdata;

   cache_word_t ref_mem   [MEM_WORDS];      // Reference copy of memory
   cache_word_t mem_model [MEM_WORDS];      // What the memory port really holds
   cache_addr_t exp_waddr;                  // Write expected at the memory port
   cache_word_t exp_wdata;
   cache_strb_t exp_wstrb;
   int          seed, dly_seed;
   int          mem_cycles = 0;             // Negedges with o_mem_valid high
   int          mem_writes = 0;             // Writes taken by the memory model
   int          cycles     = 0;

   tb_clkgen #(.PERIOD_NS(4), .RST_CYCLES(16)) u_clkgen (.o_clk(clk), .o_rst(i_rst));

   l2_id_top dut (
      .clk(clk), .i_rst(i_rst),
      .i_valid(i_valid), .i_instr(i_instr), .i_addr(i_addr),
      .i_wdata(i_wdata), .i_wstrb(i_wstrb),
      .o_rdata(o_rdata), .o_ready(o_ready),
      .o_mem_valid(o_mem_valid), .o_mem_addr(o_mem_addr),
      .o_mem_wdata(o_mem_wdata), .o_mem_wstrb(o_mem_wstrb),
      .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata)
   );

   //////////////////////////////////////////////////
   // Failure handling and compares
   //////////////////////////////////////////////////
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_word(input cache_word_t got, input cache_word_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_addr(input cache_addr_t got, input cache_addr_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_strb(input cache_strb_t got, input cache_strb_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: %s got %b, expected %b", $time, what, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: %s got %b, expected %b", $time, what, got, exp));
   endtask

   // Memory port quiet now and untouched since the snapshot
   task automatic check_mem_idle(input int cycles_before, input string what);
      if (mem_cycles != cycles_before)
         abort_run($sformatf("The memory port was used during %s", what));
      check_flag(o_mem_valid, 1'b0, what);
   endtask

   // Byte-lane mask built straight from the strobes
   function automatic cache_word_t write_bytes(cache_word_t old_w, cache_word_t new_w,
                                               cache_strb_t strb);
      cache_word_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   // One front-end transfer that starts and ends on a falling edge
   task automatic do_request(input logic instr, input cache_addr_t addr,
                             input cache_word_t wdata, input cache_strb_t wstrb,
                             output cache_word_t rdata);
      i_valid = 1'b1;
      i_instr = instr;
      i_addr  = addr;
      i_wdata = wdata;
      i_wstrb = wstrb;
      do @(negedge clk); while (!o_ready);  // Wait for the completion pulse
      rdata   = o_rdata;
      i_valid = 1'b0;
      i_wstrb = '0;
      @(negedge clk);
      check_flag(o_ready, 1'b0, "ready pulse width");   // Exactly one completion
   endtask

   //////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////
   initial begin : memory_model
      int   dly;
      logic busy;
      i_mem_ready = 1'b0;
      i_mem_rdata = '0;
      dly_seed    = 96;
      dly         = 0;
      busy        = 1'b0;
      @(negedge clk);
      while (i_rst) @(negedge clk);
      for (int a = 0; a < MEM_WORDS; a++) mem_model[a] = ref_mem[a];   // Same preload
      forever begin
         if (i_mem_ready) begin
            i_mem_ready = 1'b0;             // One-cycle pulse
         end else if (o_mem_valid) begin
            mem_cycles++;
            if (!busy) begin
               busy = 1'b1;
               dly  = $random(dly_seed) & 7;   // 0 to 7 wait cycles
            end
            if (dly == 0) begin
               busy = 1'b0;
               if (|o_mem_wstrb) begin
                  check_addr(o_mem_addr, exp_waddr, "memory write address");
                  check_word(o_mem_wdata, exp_wdata, "memory write data");
                  check_strb(o_mem_wstrb, exp_wstrb, "memory write strobes");
                  mem_model[o_mem_addr] = write_bytes(mem_model[o_mem_addr], o_mem_wdata,
                                                      o_mem_wstrb);
                  mem_writes++;
               end else begin
                  i_mem_rdata = mem_model[o_mem_addr];
               end
               i_mem_ready = 1'b1;
            end else begin
               dly--;
            end
         end
         @(negedge clk);
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES)
         abort_run($sformatf("Timeout: %0d cycles passed and the run did not finish", cycles));
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   initial begin : stimulus
      int          kind, rnd, wr_before, cyc_before;
      cache_addr_t addr;
      cache_word_t wd, rdata;
      cache_strb_t st;
      seed    = 96;
      i_valid = 1'b0;
      i_instr = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_wstrb = '0;
      for (int a = 0; a < MEM_WORDS; a++) ref_mem[a] = $random(seed);
      @(negedge clk);
      while (i_rst) @(negedge clk);
      repeat (8) begin                      // Quiet outputs before any request
         check_flag(o_ready, 1'b0, "o_ready after reset");
         check_mem_idle(0, "the idle time after reset");
         @(negedge clk);
      end
      for (int n = 0; n < NUM_OPS; n++) begin
         kind = $random(seed) & 3;
         rnd  = $random(seed);
         addr = cache_addr_t'(rnd[7:0]);
         addr[`CACHE_ADDR_W-1] = (kind != 0);  // MSB set for the data region
         wr_before = mem_writes;
         case (kind)
            0: begin                        // Instruction fetch
               do_request(1'b1, addr, '0, '0, rdata);
               check_word(rdata, ref_mem[addr], "instruction fetch");
            end
            1: begin                        // Data read
               do_request(1'b0, addr, '0, '0, rdata);
               check_word(rdata, ref_mem[addr], "data read");
            end
            2: begin                        // Data write
               wd = $random(seed);
               st = rnd[11:8];
               if (st == '0) st = 4'hF;
               exp_waddr = addr;
               exp_wdata = wd;
               exp_wstrb = st;
               do_request(1'b0, addr, wd, st, rdata);
               ref_mem[addr] = write_bytes(ref_mem[addr], wd, st);
            end
            default: begin                  // Read then the same read again
               do_request(1'b0, addr, '0, '0, rdata);
               check_word(rdata, ref_mem[addr], "first read");
               cyc_before = mem_cycles;
               do_request(1'b0, addr, '0, '0, rdata);
               check_word(rdata, ref_mem[addr], "repeat read");
               check_mem_idle(cyc_before, "a repeat read that should hit in L1");
            end
         endcase
         if (mem_writes != wr_before + ((kind == 2) ? 1 : 0))
            abort_run($sformatf("Memory took %0d writes for request %0d, kind %0d",
                                mem_writes - wr_before, n, kind));
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: l2_id_top.f
+incdir+.
cache_pkg.sv
cache_bus_if.sv
l1_cache.sv
l2_arbiter.sv
l2_cache.sv
l2_id_top.sv
tb_clkgen.sv
l2_id_tb.sv

// File: l2_id_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module l2_id_top import cache_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   // Front end
   input  logic        i_valid,
   input  logic        i_instr,             // Steers to the instruction cache
   input  cache_addr_t i_addr,
   input  cache_word_t i_wdata,
   input  cache_strb_t i_wstrb,
   output cache_word_t o_rdata,
   output logic        o_ready,
   // Native memory port
   output logic        o_mem_valid,
   output cache_addr_t o_mem_addr,
   output cache_word_t o_mem_wdata,
   output cache_strb_t o_mem_wstrb,
   input  logic        i_mem_ready,
   input  cache_word_t i_mem_rdata
);

   cache_bus_if l1i_mem ();                 // L1-I to arbiter
   cache_bus_if l1d_mem ();                 // L1-D to arbiter
   cache_bus_if l2_front ();                // Arbiter to L2

   cache_word_t icache_rdata, dcache_rdata;
   logic        icache_ready, dcache_ready;

   //////////////////////////////////////////////////
   // Response merge
   //////////////////////////////////////////////////
   assign o_ready = icache_ready | dcache_ready;
   assign o_rdata = dcache_ready ? dcache_rdata : icache_rdata;

   // Instruction side
   l1_cache #(.IDX_W(`L1_IDX_W)) l1_icache (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_valid (i_valid & i_instr),
      .i_addr  (i_addr),
      .i_wdata (i_wdata),
      .i_wstrb (i_wstrb),
      .o_rdata (icache_rdata),
      .o_ready (icache_ready),
      .mem     (l1i_mem)
   );

   // Data side
   l1_cache #(.IDX_W(`L1_IDX_W)) l1_dcache (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_valid (i_valid & ~i_instr),
      .i_addr  (i_addr),
      .i_wdata (i_wdata),
      .i_wstrb (i_wstrb),
      .o_rdata (dcache_rdata),
      .o_ready (dcache_ready),
      .mem     (l1d_mem)
   );

   l2_arbiter u_arbiter (
      .clk   (clk),
      .i_rst (i_rst),
      .l1i   (l1i_mem),
      .l1d   (l1d_mem),
      .l2    (l2_front)
   );

   l2_cache #(.IDX_W(`L2_IDX_W)) u_l2 (
      .clk         (clk),
      .i_rst       (i_rst),
      .front       (l2_front),
      .o_mem_valid (o_mem_valid),
      .o_mem_addr  (o_mem_addr),
      .o_mem_wdata (o_mem_wdata),
      .o_mem_wstrb (o_mem_wstrb),
      .i_mem_ready (i_mem_ready),
      .i_mem_rdata (i_mem_rdata)
   );

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module l2_id_tb -f l2_id_top.f \
   -o sim_l2_id > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_l2_id > sim.log 2>&1 ; cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

// File: tb_clkgen.sv
`timescale 1ns/1ps

// Free-running clock and a power-on reset pulse
module tb_clkgen #(
   parameter int PERIOD_NS  = 4,            // Full clock period
   parameter int RST_CYCLES = 16            // Reset length in clock cycles
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
   end

   initial begin
      o_rst <= 1'b1;                        // Held from time zero
      repeat (RST_CYCLES) @(posedge o_clk);
      o_rst <= 1'b0;                        // Released just after an edge
   end

endmodule
